/* hdl/snk_video_pkg.sv */
// video path shared definitions
`default_nettype none

package snk_video_pkg;

  // ==========================================================================
  // raster geometry
  // ==========================================================================
  localparam int H_TOTAL     = 384;  // pixels per line
  localparam int H_ACTIVE    = 256;  // hc 0..255 visible
  localparam int V_TOTAL     = 264;
  localparam int V_START     = 16;   // first visible line
  localparam int V_END       = 239;  // last visible line
  localparam int HSYNC_START = 288;
  localparam int HSYNC_LEN   = 32;
  localparam int VSYNC_START = 244;
  localparam int VSYNC_LEN   = 8;

  // pixels from raster count to rgb out: 4 in the text layer, 2 in the palette
  localparam int PIX_DELAY = 6;

  localparam logic [10:0] BG_PEN = 11'h7ff;

  // ==========================================================================
  // host address map and memory sizes
  // ==========================================================================
  localparam logic [23:0] FG_RAM_BASE   = 24'h0C0000;
  localparam logic [23:0] PAL_BASE      = 24'h400000;
  localparam logic [23:0] FLIP_REG_ADDR = 24'h080000;  // flip in data bit 3

  localparam int FG_RAM_AW = 11;  // words
  localparam int PAL_AW    = 11;
  localparam int GFX_AW    = 15;

  typedef struct packed {
    logic [23:0] addr;  // byte address, or word offset after decode
    logic [15:0] data;
    logic [1:0]  be;    // upper, lower
  } host_wr_t;

  typedef struct packed {
    logic [8:0] hc;
    logic [8:0] vc;
  } raster_t;

  typedef struct packed {
    logic [4:0] r;
    logic [4:0] g;
    logic [4:0] b;
  } rgb_t;

endpackage

`default_nettype wire

/* hdl/dual_port_ram.sv */
// byte-writable RAM with registered read
`timescale 1ns/10ps
`default_nettype none

module dual_port_ram #(
  parameter int AW = 11,
  parameter int DW = 16
) (
  input  wire            clk_sys,
  input  wire            we,
  input  wire [DW/8-1:0] be,
  input  wire [AW-1:0]   waddr,
  input  wire [DW-1:0]   wdata,
  input  wire [AW-1:0]   raddr,
  output logic [DW-1:0]  rdata
);

  logic [DW-1:0] mem [0:(1 << AW) - 1];

  always_ff @(posedge clk_sys) begin
    if (we) begin
      for (int i = 0; i < DW / 8; i++) begin
        if (be[i]) mem[waddr][i*8 +: 8] <= wdata[i*8 +: 8];  // lane i
      end
    end
  end

  // one clock of read latency
  always_ff @(posedge clk_sys) begin
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

/* hdl/video_timing.sv */
// raster timing generator
`timescale 1ns/10ps
`default_nettype none

module video_timing #(
  parameter int CE_DIV = 12
) (
  input  wire                    clk_sys,
  input  wire                    reset,
  output logic                   ce_pix,
  output snk_video_pkg::raster_t raster,
  output logic                   hbl,
  output logic                   vbl,
  output logic                   hsync,
  output logic                   vsync
);

  localparam int DIV_W = (CE_DIV > 1) ? $clog2(CE_DIV) : 1;

  logic [DIV_W-1:0] div_cnt;
  logic [8:0]       hc;
  logic [8:0]       vc;
  logic [8:0]       hc_nxt;
  logic [8:0]       vc_nxt;

  // ==========================================================================
  // pixel clock enable
  // ==========================================================================
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      div_cnt <= '0;
      ce_pix  <= 1'b0;
    end else begin
      ce_pix  <= (div_cnt == DIV_W'(CE_DIV - 1));
      div_cnt <= (div_cnt == DIV_W'(CE_DIV - 1)) ? '0 : div_cnt + 1'b1;
    end
  end

  // ==========================================================================
  // counters, with blanking and sync decoded from the next count
  // ==========================================================================
  always_comb begin
    hc_nxt = (hc == 9'(snk_video_pkg::H_TOTAL - 1)) ? 9'd0 : hc + 9'd1;
    vc_nxt = vc;
    if (hc == 9'(snk_video_pkg::H_TOTAL - 1)) begin
      vc_nxt = (vc == 9'(snk_video_pkg::V_TOTAL - 1)) ? 9'd0 : vc + 9'd1;
    end
  end

  // reset parks on the last pixel of the frame so the flags agree with the counts
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      hc    <= 9'(snk_video_pkg::H_TOTAL - 1);
      vc    <= 9'(snk_video_pkg::V_TOTAL - 1);
      hbl   <= 1'b1;
      vbl   <= 1'b1;
      hsync <= 1'b0;
      vsync <= 1'b0;
    end else if (ce_pix) begin
      hc    <= hc_nxt;
      vc    <= vc_nxt;
      hbl   <= (hc_nxt >= 9'(snk_video_pkg::H_ACTIVE));
      vbl   <= (vc_nxt < 9'(snk_video_pkg::V_START)) || (vc_nxt > 9'(snk_video_pkg::V_END));
      hsync <= (hc_nxt >= 9'(snk_video_pkg::HSYNC_START)) &&
               (hc_nxt < 9'(snk_video_pkg::HSYNC_START + snk_video_pkg::HSYNC_LEN));
      vsync <= (vc_nxt >= 9'(snk_video_pkg::VSYNC_START)) &&
               (vc_nxt < 9'(snk_video_pkg::VSYNC_START + snk_video_pkg::VSYNC_LEN));
    end
  end

  assign raster = '{hc: hc, vc: vc};

  // the RAM reads downstream need at least one idle clock between pixels
  a_ce_single : assert property (@(posedge clk_sys) disable iff (reset)
    ce_pix |=> !ce_pix);

endmodule

`default_nettype wire

/* hdl/video_regs.sv */
// host write decode and flip register
`timescale 1ns/10ps
`default_nettype none

module video_regs (
  input  wire                      clk_sys,
  input  wire                      reset,
  input  wire snk_video_pkg::host_wr_t host_wr,
  input  wire                      host_we,
  output logic                     fg_we,
  output logic                     pal_we,
  output snk_video_pkg::host_wr_t  ram_wr,
  output logic                     flip
);

  // word offset wide enough for the larger of the two RAMs
  localparam int WORD_AW = (snk_video_pkg::FG_RAM_AW > snk_video_pkg::PAL_AW) ?
                           snk_video_pkg::FG_RAM_AW : snk_video_pkg::PAL_AW;

  logic fg_hit;
  logic pal_hit;
  logic flip_hit;

  // windows are sized by the RAM depth, 2 bytes per word
  assign fg_hit  = host_wr.addr[23:snk_video_pkg::FG_RAM_AW+1] ==
                   snk_video_pkg::FG_RAM_BASE[23:snk_video_pkg::FG_RAM_AW+1];
  assign pal_hit = host_wr.addr[23:snk_video_pkg::PAL_AW+1] ==
                   snk_video_pkg::PAL_BASE[23:snk_video_pkg::PAL_AW+1];
  assign flip_hit = host_wr.addr[23:1] == snk_video_pkg::FLIP_REG_ADDR[23:1];

  assign fg_we  = host_we & fg_hit;
  assign pal_we = host_we & pal_hit;

  always_comb begin
    ram_wr      = host_wr;
    ram_wr.addr = 24'(host_wr.addr[WORD_AW:1]);  // byte address to word offset
  end

  // bit 3 sits in the low byte
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      flip <= 1'b0;
    end else if (host_we && flip_hit && host_wr.be[0]) begin
      flip <= host_wr.data[3];
    end
  end

  a_one_ram : assert property (@(posedge clk_sys) disable iff (reset)
    !(fg_we && pal_we));

endmodule

`default_nettype wire

/* hdl/fg_layer.sv */
// foreground text layer
`timescale 1ns/10ps
`default_nettype none

module fg_layer (
  input  wire                        clk_sys,
  input  wire                        reset,
  input  wire                        ce_pix,
  input  wire snk_video_pkg::raster_t raster,
  input  wire                        flip,
  input  wire                        fg_we,
  input  wire snk_video_pkg::host_wr_t ram_wr,
  input  wire                        rom_download,
  input  wire                        ioctl_wr,
  input  wire [23:0]                 ioctl_addr,
  input  wire [7:0]                  ioctl_dout,
  output logic [10:0]                pen_index
);

  localparam int MAP_AW = snk_video_pkg::FG_RAM_AW;
  localparam int ROM_AW = snk_video_pkg::GFX_AW;
  localparam logic WORD_SEL = 1'b0;  // tile code and colour live in word 0

  logic [8:0]        fx;
  logic [8:0]        fy;
  logic [MAP_AW-1:0] map_raddr;
  logic [15:0]       map_rdata;
  logic              gfx_we;
  logic [1:0]        gfx_be;
  logic [ROM_AW-1:0] gfx_raddr;
  logic [15:0]       gfx_rdata;
  logic [15:0]       pix_data;
  logic [3:0]        colour_q;
  logic [3:0]        colour_d;
  logic [1:0]        phase;
  logic [1:0]        ser_n;
  logic [3:0]        pen;

  // screen flip mirrors the low 8 bits of each count
  assign fx = flip ? {raster.hc[8], ~raster.hc[7:0]} : raster.hc;
  assign fy = flip ? {raster.vc[8], ~raster.vc[7:0]} : raster.vc;

  // ==========================================================================
  // tile-map RAM, host written
  // ==========================================================================
  assign map_raddr = {fx[7:3], fy[7:3], WORD_SEL};

  dual_port_ram #(.AW(MAP_AW), .DW(16)) u_map_ram (
    .clk_sys (clk_sys),
    .we      (fg_we),
    .be      (ram_wr.be),
    .waddr   (ram_wr.addr[MAP_AW-1:0]),
    .wdata   (ram_wr.data),
    .raddr   (map_raddr),
    .rdata   (map_rdata)
  );

  // ==========================================================================
  // graphics ROM, byte loaded, even byte goes high
  // ==========================================================================
  assign gfx_we = rom_download & ioctl_wr & (ioctl_addr[23:ROM_AW+1] == '0);
  assign gfx_be = {~ioctl_addr[0], ioctl_addr[0]};

  dual_port_ram #(.AW(ROM_AW), .DW(16)) u_gfx_rom (
    .clk_sys (clk_sys),
    .we      (gfx_we),
    .be      (gfx_be),
    .waddr   (ioctl_addr[ROM_AW:1]),
    .wdata   ({ioctl_dout, ioctl_dout}),
    .raddr   (gfx_raddr),
    .rdata   (gfx_rdata)
  );

  // ==========================================================================
  // fetch pipeline, one ROM word per 4 pixels
  // ==========================================================================
  assign phase = raster.hc[1:0];

  // phase 0 reads the map, phase 2 takes the ROM word
  always_ff @(posedge clk_sys) begin
    if (ce_pix) begin
      if (phase == 2'd0) begin
        gfx_raddr <= {map_rdata[10:0], ~fx[2], fy[2:0]};  // left half has x[2] clear
        colour_q  <= map_rdata[15:12];
      end
      if (phase == 2'd2) begin
        pix_data <= gfx_rdata;
        colour_d <= colour_q;
      end
    end
  end

  // serializer runs one phase behind the load, so pixel n = phase + 1
  assign ser_n = (phase + 2'd1) ^ {2{flip}};
  assign pen   = {pix_data[12 + ser_n], pix_data[8 + ser_n],
                  pix_data[4 + ser_n], pix_data[ser_n]};

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      pen_index <= '0;
    end else if (ce_pix) begin
      pen_index <= {3'b000, colour_d, pen};
    end
  end

endmodule

`default_nettype wire

/* hdl/palette_mixer.sv */
// palette lookup and colour output
`timescale 1ns/10ps
`default_nettype none

module palette_mixer (
  input  wire                        clk_sys,
  input  wire                        reset,
  input  wire                        ce_pix,
  input  wire [10:0]                 pen_index,
  input  wire                        hbl,
  input  wire                        vbl,
  input  wire                        pal_we,
  input  wire snk_video_pkg::host_wr_t ram_wr,
  output snk_video_pkg::rgb_t        rgb,
  output logic                       hbl_out,
  output logic                       vbl_out
);

  localparam int AW  = snk_video_pkg::PAL_AW;
  localparam int DLY = snk_video_pkg::PIX_DELAY;

  logic [AW-1:0]  pal_raddr;
  logic [15:0]    pal_rdata;
  logic [DLY-1:0] hbl_sr;
  logic [DLY-1:0] vbl_sr;

  // transparent pen shows the background entry
  always_ff @(posedge clk_sys) begin
    if (ce_pix) begin
      pal_raddr <= (pen_index[3:0] == 4'd0) ? snk_video_pkg::BG_PEN : pen_index;
    end
  end

  dual_port_ram #(.AW(AW), .DW(16)) u_pal_ram (
    .clk_sys (clk_sys),
    .we      (pal_we),
    .be      (ram_wr.be),
    .waddr   (ram_wr.addr[AW-1:0]),
    .wdata   (ram_wr.data),
    .raddr   (pal_raddr),
    .rdata   (pal_rdata)
  );

  // ==========================================================================
  // output register with blanking kept in step with the colour
  // ==========================================================================
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      rgb    <= '0;
      hbl_sr <= '1;
      vbl_sr <= '1;
    end else if (ce_pix) begin
      // 4 data bits then the intensity bit of each channel
      rgb    <= '{r: {pal_rdata[11:8], pal_rdata[14]},
                  g: {pal_rdata[7:4],  pal_rdata[13]},
                  b: {pal_rdata[3:0],  pal_rdata[12]}};
      hbl_sr <= {hbl_sr[DLY-2:0], hbl};
      vbl_sr <= {vbl_sr[DLY-2:0], vbl};
    end
  end

  assign hbl_out = hbl_sr[DLY-1];
  assign vbl_out = vbl_sr[DLY-1];

  // palette read data only lands a clock after the address
  a_ce_gap : assert property (@(posedge clk_sys) disable iff (reset)
    ce_pix |=> !ce_pix);

endmodule

`default_nettype wire

/* hdl/snk_video_top.sv */
// arcade display path top level
`timescale 1ns/10ps
`default_nettype none

module snk_video_top #(
  parameter int CE_DIV = 12  // 72 MHz to 6 MHz
) (
  input  wire                        clk_sys,
  input  wire                        reset,
  input  wire snk_video_pkg::host_wr_t host_wr,
  input  wire                        host_we,
  input  wire                        rom_download,
  input  wire                        ioctl_wr,
  input  wire [23:0]                 ioctl_addr,
  input  wire [7:0]                  ioctl_dout,
  output snk_video_pkg::rgb_t        rgb,
  output logic                       hbl,
  output logic                       vbl,
  output logic                       hsync,
  output logic                       vsync,
  output logic                       ce_pix
);

  snk_video_pkg::raster_t  raster;
  snk_video_pkg::host_wr_t ram_wr;
  logic                    raw_hbl;   // undelayed, from the counters
  logic                    raw_vbl;
  logic                    fg_we;
  logic                    pal_we;
  logic                    flip;
  logic [10:0]             pen_index;

  // ==========================================================================
  // timing and host registers
  // ==========================================================================
  video_timing #(.CE_DIV(CE_DIV)) u_timing (
    .clk_sys (clk_sys),
    .reset   (reset),
    .ce_pix  (ce_pix),
    .raster  (raster),
    .hbl     (raw_hbl),
    .vbl     (raw_vbl),
    .hsync   (hsync),
    .vsync   (vsync)
  );

  video_regs u_regs (
    .clk_sys (clk_sys),
    .reset   (reset),
    .host_wr (host_wr),
    .host_we (host_we),
    .fg_we   (fg_we),
    .pal_we  (pal_we),
    .ram_wr  (ram_wr),
    .flip    (flip)
  );

  // ==========================================================================
  // pixel path
  // ==========================================================================
  fg_layer u_fg (
    .clk_sys      (clk_sys),
    .reset        (reset),
    .ce_pix       (ce_pix),
    .raster       (raster),
    .flip         (flip),
    .fg_we        (fg_we),
    .ram_wr       (ram_wr),
    .rom_download (rom_download),
    .ioctl_wr     (ioctl_wr),
    .ioctl_addr   (ioctl_addr),
    .ioctl_dout   (ioctl_dout),
    .pen_index    (pen_index)
  );

  palette_mixer u_pal (
    .clk_sys   (clk_sys),
    .reset     (reset),
    .ce_pix    (ce_pix),
    .pen_index (pen_index),
    .hbl       (raw_hbl),
    .vbl       (raw_vbl),
    .pal_we    (pal_we),
    .ram_wr    (ram_wr),
    .rgb       (rgb),
    .hbl_out   (hbl),
    .vbl_out   (vbl)
  );

endmodule

`default_nettype wire

/* testbench/tb_snk_video.sv */
// display path testbench
`timescale 1ns/10ps
`default_nettype none

module tb_snk_video;

  localparam int CE_DIV    = 4;
  localparam int NUM_TESTS = 10;
  localparam int PIX_LIMIT = 2 * snk_video_pkg::H_TOTAL * snk_video_pkg::V_TOTAL;
  localparam logic [1:0] K_LINES = 2'd0;  // hsync edges per frame
  localparam logic [1:0] K_WIDTH = 2'd1;  // visible pixels per line
  localparam logic [1:0] K_PIXEL = 2'd2;

  typedef struct packed {
    logic [1:0]                    kind;
    logic [1:0]                    nwr;
    snk_video_pkg::host_wr_t [2:0] wr;
    logic                          flip;
    logic [8:0]                    x;
    logic [8:0]                    y;
    logic [15:0]                   exp_val;  // expected count for the count tests
  } test_t;

  logic                    clk_sys;
  logic                    reset;
  snk_video_pkg::host_wr_t host_wr;
  logic                    host_we;
  logic                    rom_download;
  logic                    ioctl_wr;
  logic [23:0]             ioctl_addr;
  logic [7:0]              ioctl_dout;
  snk_video_pkg::rgb_t     rgb;
  logic                    hbl;
  logic                    vbl;
  logic                    hsync;
  logic                    vsync;
  logic                    ce_pix;

  logic [15:0] gfx_mem [0:(1 << snk_video_pkg::GFX_AW) - 1];  // reference copies
  logic [15:0] map_mem [0:(1 << snk_video_pkg::FG_RAM_AW) - 1];
  logic [15:0] pal_mem [0:(1 << snk_video_pkg::PAL_AW) - 1];
  logic        model_flip;

  snk_video_pkg::rgb_t s_rgb;  // one sample per pixel
  logic s_hbl;
  logic s_vbl;
  logic s_hs;
  logic s_vs;
  logic p_hbl;  // previous pixel
  logic p_vbl;
  logic p_hs;
  logic p_vs;

  test_t tests [NUM_TESTS];
  string test_name [NUM_TESTS];
  int    errors;
  int    passes;
  logic  timed_out;

  initial begin
    clk_sys = 1'b0;
    forever #2 clk_sys = ~clk_sys;
  end

  snk_video_top #(.CE_DIV(CE_DIV)) DUT (
    .clk_sys      (clk_sys),
    .reset        (reset),
    .host_wr      (host_wr),
    .host_we      (host_we),
    .rom_download (rom_download),
    .ioctl_wr     (ioctl_wr),
    .ioctl_addr   (ioctl_addr),
    .ioctl_dout   (ioctl_dout),
    .rgb          (rgb),
    .hbl          (hbl),
    .vbl          (vbl),
    .hsync        (hsync),
    .vsync        (vsync),
    .ce_pix       (ce_pix)
  );

  // ==========================================================================
  // reference model
  // ==========================================================================
  function automatic logic [15:0] merge_bytes(input logic [15:0] old,
                                              input logic [15:0] data,
                                              input logic [1:0] be);
    merge_bytes = old;
    if (be[1]) merge_bytes[15:8] = data[15:8];
    if (be[0]) merge_bytes[7:0] = data[7:0];
  endfunction

  function automatic snk_video_pkg::rgb_t model_rgb(input logic [8:0] x, input logic [8:0] y);
    logic [8:0]  fx;
    logic [8:0]  fy;
    logic [15:0] tile;
    logic [15:0] gw;
    logic [15:0] pw;
    logic [3:0]  pen;
    logic [10:0] idx;
    int          n;
    fx = x;
    fy = y;
    if (model_flip) begin
      fx[7:0] = ~x[7:0];  // top bit stays
      fy[7:0] = ~y[7:0];
    end
    tile = map_mem[{fx[7:3], fy[7:3], 1'b0}];
    gw   = gfx_mem[{tile[10:0], ~fx[2], fy[2:0]}];
    n    = int'(fx[1:0]);
    pen  = {gw[12 + n], gw[8 + n], gw[4 + n], gw[n]};
    idx  = (pen == 4'd0) ? snk_video_pkg::BG_PEN : {3'b000, tile[15:12], pen};
    pw   = pal_mem[idx];
    model_rgb = '{r: {pw[11:8], pw[14]}, g: {pw[7:4], pw[13]}, b: {pw[3:0], pw[12]}};
  endfunction

  // ==========================================================================
  // drivers and monitors
  // ==========================================================================
  task automatic check_timeout(input int cnt, input int limit, input string what);
    if (cnt >= limit && !timed_out) begin
      $display("timed out waiting for %s", what);
      timed_out = 1'b1;
    end
  endtask

  task automatic next_pixel();
    int cnt;
    cnt = 0;
    @(negedge clk_sys);
    while (!ce_pix && cnt < 4 * CE_DIV) begin
      @(negedge clk_sys);
      cnt++;
    end
    check_timeout(cnt, 4 * CE_DIV, "the pixel enable");
    @(negedge clk_sys);  // outputs settled after the pixel edge
    {p_hbl, p_vbl, p_hs, p_vs} = {s_hbl, s_vbl, s_hs, s_vs};
    {s_hbl, s_vbl, s_hs, s_vs} = {hbl, vbl, hsync, vsync};
    s_rgb = rgb;
  endtask

  task automatic host_write(input logic [23:0] addr, input logic [15:0] data,
                            input logic [1:0] be);
    logic [10:0] word;
    @(posedge clk_sys);
    #1;
    host_wr = '{addr: addr, data: data, be: be};
    host_we = 1'b1;
    @(posedge clk_sys);
    #1;
    host_we = 1'b0;
    word = addr[11:1];
    if ((addr >> (snk_video_pkg::FG_RAM_AW + 1)) ==
        (snk_video_pkg::FG_RAM_BASE >> (snk_video_pkg::FG_RAM_AW + 1))) begin
      map_mem[word] = merge_bytes(map_mem[word], data, be);
    end else if ((addr >> (snk_video_pkg::PAL_AW + 1)) ==
                 (snk_video_pkg::PAL_BASE >> (snk_video_pkg::PAL_AW + 1))) begin
      pal_mem[word] = merge_bytes(pal_mem[word], data, be);
    end else if (addr[23:1] == snk_video_pkg::FLIP_REG_ADDR[23:1] && be[0]) begin
      model_flip = data[3];
    end
  endtask

  // tile 0 blank, tile 1 solid pen 15, the rest random
  task automatic load_gfx_rom();
    logic [15:0] word;
    @(posedge clk_sys);
    #1 rom_download = 1'b1;
    for (int a = 0; a < (1 << snk_video_pkg::GFX_AW); a++) begin
      if (a[14:4] == 11'd0) word = 16'h0000;
      else if (a[14:4] == 11'd1) word = 16'hffff;
      else word = 16'($urandom);
      gfx_mem[a] = word;
      for (int b = 0; b < 2; b++) begin
        @(posedge clk_sys);
        #1;
        ioctl_addr = 24'(2 * a + b);
        ioctl_dout = (b == 0) ? word[15:8] : word[7:0];  // even byte is the upper one
        ioctl_wr   = 1'b1;
        @(posedge clk_sys);
        #1 ioctl_wr = 1'b0;
      end
    end
    rom_download = 1'b0;
  endtask

  // one full frame from vsync rise to vsync rise
  task automatic scan_frame(output int lines, output int width);
    int cnt;
    int run;
    bit started;
    bit done;
    cnt = 0;
    run = 0;
    lines = 0;
    width = 0;
    started = 1'b0;
    done = 1'b0;
    next_pixel();
    while (!done && cnt < PIX_LIMIT && !timed_out) begin
      next_pixel();
      cnt++;
      if (s_vs && !p_vs) begin
        done = started;
        started = 1'b1;
      end
      if (started && !done) begin
        if (s_hs && !p_hs) lines++;
        if (!s_hbl) run++;
        if (s_hbl && !p_hbl) begin
          if (width == 0 || width == snk_video_pkg::H_ACTIVE) width = run;
          run = 0;
        end
      end
    end
    check_timeout(cnt, PIX_LIMIT, "two vsync edges");
  endtask

  task automatic capture_pixel(input int x, input int y, output snk_video_pkg::rgb_t val);
    int cnt;
    int line;
    int k;
    cnt = 0;
    line = snk_video_pkg::V_START;
    k = 0;
    next_pixel();
    do begin
      next_pixel();
      cnt++;
    end while (!(p_vbl && !s_vbl) && cnt < PIX_LIMIT && !timed_out);
    check_timeout(cnt, PIX_LIMIT, "the start of the visible frame");
    while (!(line == y && k == x) && cnt < PIX_LIMIT && !timed_out) begin
      next_pixel();
      cnt++;
      if (!s_hbl) begin
        if (p_hbl) begin
          line++;
          k = 0;
        end else begin
          k++;
        end
      end
    end
    check_timeout(cnt, PIX_LIMIT, "the requested screen pixel");
    val = s_rgb;
  endtask

  // ==========================================================================
  // test table
  // ==========================================================================
  task automatic set_test(input int i, input string name, input logic [1:0] kind,
                          input logic flip, input int x, input int y, input int exp_val);
    test_name[i] = name;
    tests[i] = '0;
    tests[i].kind = kind;
    tests[i].flip = flip;
    tests[i].x = 9'(x);
    tests[i].y = 9'(y);
    tests[i].exp_val = 16'(exp_val);
  endtask

  task automatic add_write(input int i, input logic [23:0] addr, input logic [15:0] data,
                           input logic [1:0] be);
    tests[i].wr[tests[i].nwr] = '{addr: addr, data: data, be: be};
    tests[i].nwr = tests[i].nwr + 2'd1;
  endtask

  task automatic build_table();
    set_test(0, "frame_lines", K_LINES, 1'b0, 0, 0, snk_video_pkg::V_TOTAL);
    set_test(1, "line_width", K_WIDTH, 1'b0, 0, 0, snk_video_pkg::H_ACTIVE);
    set_test(2, "pixel_first", K_PIXEL, 1'b0, 0, 16, 0);
    set_test(3, "pixel_mid", K_PIXEL, 1'b0, 133, 77, 0);
    set_test(4, "pixel_last", K_PIXEL, 1'b0, 255, 239, 0);
    set_test(5, "bg_pen", K_PIXEL, 1'b0, 40, 100, 0);
    add_write(5, 24'h0C02B0, 16'h5000, 2'b11);   // blank tile in colour 5
    add_write(5, 24'h400FFE, 16'h4A52, 2'b11);   // background entry
    set_test(6, "pal_upper_byte", K_PIXEL, 1'b0, 201, 50, 0);
    add_write(6, 24'h0C0C98, 16'h3001, 2'b11);   // solid tile at palette index 0x03f
    add_write(6, 24'h40007E, 16'h1234, 2'b11);
    add_write(6, 24'h40007E, 16'hABCD, 2'b10);
    set_test(7, "flip_bg", K_PIXEL, 1'b1, 215, 155, 0);  // mirror of the blank tile
    set_test(8, "flip_mid", K_PIXEL, 1'b1, 133, 77, 0);
    set_test(9, "unflip", K_PIXEL, 1'b0, 40, 100, 0);
  endtask

  initial begin
    snk_video_pkg::rgb_t got_rgb;
    logic [15:0]         got;
    logic [15:0]         exp;
    int                  lines;
    int                  width;
    void'($urandom(1));
    reset = 1'b1;
    host_wr = '0;
    host_we = 1'b0;
    rom_download = 1'b0;
    ioctl_wr = 1'b0;
    ioctl_addr = '0;
    ioctl_dout = '0;
    model_flip = 1'b0;
    timed_out = 1'b0;
    {s_hbl, s_vbl, s_hs, s_vs, s_rgb} = '0;
    errors = 0;
    passes = 0;
    repeat (16) @(posedge clk_sys);
    #1 reset = 1'b0;
    build_table();
    load_gfx_rom();
    for (int i = 0; i < (1 << snk_video_pkg::FG_RAM_AW); i++) begin
      host_write(snk_video_pkg::FG_RAM_BASE + 24'(2 * i), 16'($urandom), 2'b11);
      host_write(snk_video_pkg::PAL_BASE + 24'(2 * i), 16'($urandom), 2'b11);
    end
    for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
      host_write(snk_video_pkg::FLIP_REG_ADDR, {12'h000, tests[t].flip, 3'b000}, 2'b01);
      for (int w = 0; w < int'(tests[t].nwr); w++) begin
        host_write(tests[t].wr[w].addr, tests[t].wr[w].data, tests[t].wr[w].be);
      end
      if (tests[t].kind == K_PIXEL) begin
        capture_pixel(int'(tests[t].x), int'(tests[t].y), got_rgb);
        got = 16'(got_rgb);
        exp = 16'(model_rgb(tests[t].x, tests[t].y));
      end else begin
        scan_frame(lines, width);
        got = (tests[t].kind == K_LINES) ? 16'(lines) : 16'(width);
        exp = tests[t].exp_val;
      end
      if (timed_out) begin
        errors++;
      end else begin
        assert (got == exp) else begin
          $display("CHECK FAILED %s expected 0x%04h actual 0x%04h", test_name[t], exp, got);
          errors++;
        end
        if (got == exp) passes++;
      end
      $display("test %s %s", test_name[t], (!timed_out && got == exp) ? "passed" : "failed");
    end
    $display("%0d tests run, %0d passed, %0d failed", passes + errors, passes, errors);
    if (errors == 0 && !timed_out) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
hdl/snk_video_pkg.sv
hdl/dual_port_ram.sv
hdl/video_timing.sv
hdl/video_regs.sv
hdl/fg_layer.sv
hdl/palette_mixer.sv
hdl/snk_video_top.sv
testbench/tb_snk_video.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the display path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_snk_video \
  -f verilog.f -o tb_snk_video
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_snk_video)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1
